/* vlog.f */
design/cache_pkg.sv
design/request_arbiter.sv
design/request_address_decode.sv
design/request_fifo.sv
design/cache_request_generator.sv
bench/cache_request_generator_tb.sv

/* Makefile */
# Verilator build and run for the cache request generator

VERILATOR  ?= verilator
TOP        ?= cache_request_generator_tb
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
FAIL_MSG   ?= Verification failed
PASS_MSG   ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/cache_request_generator_tb.sv */
// Table-driven testbench for the cache request generator, run as the simulation top module
`timescale 1ns/100ps

module cache_request_generator_tb;
  import cache_pkg::*;

  // One stimulus row, owning requestor first
  typedef struct packed {
    logic [source_w-1:0]    req;
    cmd_t                   cmd;
    logic [num_buffers-1:0] id_buffer;
    logic [addr_w-1:0]      offset;
    logic [data_w-1:0]      data;
  } stim_t;

  localparam int table_len      = 32;
  localparam int phase_a_len    = 20;
  localparam int timeout_cycles = table_len * 40;

  // --------------------------------------
  // Stimulus table
  // --------------------------------------
  // Rows 0-19 mixed traffic, every buffer id and every command
  // Rows 20-31 memory burst for back-pressure
  stim_t stim_table [table_len] = '{
    '{1'b0, cmd_mem_read,     8'h01, 32'h0000_0010, 32'ha000_0000},
    '{1'b1, cmd_mem_write,    8'h02, 32'h0000_0024, 32'ha111_1111},
    '{1'b0, cmd_mem_write,    8'h04, 32'h0000_0038, 32'ha222_2222},
    '{1'b1, cmd_mem_read,     8'h08, 32'h0000_004c, 32'ha333_3333},
    '{1'b0, cmd_mem_response, 8'h10, 32'h0000_0050, 32'ha444_4444},
    '{1'b1, cmd_mem_read,     8'h10, 32'h0000_0060, 32'ha555_5555},
    '{1'b0, cmd_mem_write,    8'h20, 32'h0000_0074, 32'ha666_6666},
    '{1'b1, cmd_engine,       8'h40, 32'h0000_0080, 32'ha777_7777},
    '{1'b0, cmd_mem_read,     8'h40, 32'h0000_0094, 32'ha888_8888},
    '{1'b1, cmd_mem_write,    8'h80, 32'h0000_00a8, 32'ha999_9999},
    '{1'b0, cmd_invalid,      8'h01, 32'h0000_00b0, 32'haaaa_aaaa},
    '{1'b1, cmd_mem_read,     8'h00, 32'h0000_00c4, 32'habbb_bbbb},
    '{1'b0, cmd_mem_write,    8'h03, 32'h0000_00d8, 32'hac0c_0c0c},
    '{1'b1, cmd_mem_write,    8'hff, 32'h0000_00ec, 32'had0d_0d0d},
    '{1'b0, cmd_mem_read,     8'h80, 32'h0000_0100, 32'hae0e_0e0e},
    '{1'b1, cmd_mem_response, 8'h02, 32'h0000_0114, 32'haf0f_0f0f},
    '{1'b0, cmd_mem_write,    8'h01, 32'hffff_f000, 32'hb010_1010},
    '{1'b1, cmd_mem_read,     8'h20, 32'h0000_0128, 32'hb111_1111},
    '{1'b0, cmd_engine,       8'h08, 32'h0000_013c, 32'hb212_1212},
    '{1'b1, cmd_mem_write,    8'h04, 32'h0000_0150, 32'hb313_1313},
    '{1'b0, cmd_mem_write,    8'h01, 32'h0000_0200, 32'hc000_0001},
    '{1'b1, cmd_mem_read,     8'h02, 32'h0000_0204, 32'hc000_0002},
    '{1'b0, cmd_mem_read,     8'h04, 32'h0000_0208, 32'hc000_0003},
    '{1'b1, cmd_mem_write,    8'h08, 32'h0000_020c, 32'hc000_0004},
    '{1'b0, cmd_mem_write,    8'h10, 32'h0000_0210, 32'hc000_0005},
    '{1'b1, cmd_mem_read,     8'h20, 32'h0000_0214, 32'hc000_0006},
    '{1'b0, cmd_mem_read,     8'h40, 32'h0000_0218, 32'hc000_0007},
    '{1'b1, cmd_mem_write,    8'h80, 32'h0000_021c, 32'hc000_0008},
    '{1'b0, cmd_mem_write,    8'h00, 32'h0000_0220, 32'hc000_0009},
    '{1'b1, cmd_mem_read,     8'h11, 32'h0000_0224, 32'hc000_000a},
    '{1'b0, cmd_mem_read,     8'h02, 32'h0000_0228, 32'hc000_000b},
    '{1'b1, cmd_mem_write,    8'h01, 32'h0000_022c, 32'hc000_000c}
  };

  logic                             ap_clk;
  logic                             areset_control;
  kernel_descriptor_t               descriptor_in;
  mem_packet_t [num_requestors-1:0] request_in;
  logic [num_requestors-1:0]        arbiter_request_in;
  logic [num_requestors-1:0]        arbiter_grant_out;
  logic                             pop_en;
  fifo_status_t                     fifo_status_out;
  cache_request_t                   request_out;
  logic                             request_out_valid;
  logic                             fifo_setup;

  // Scoreboard state
  logic [addr_w-1:0] base_tab [num_buffers+1];
  cache_request_t    exp_q [$];
  int                cur [num_requestors];
  int                pos [num_requestors];
  int                release_cnt;
  int                grant_cnt;
  int                checked_cnt;
  int                exp_total;
  int                last_grant;
  int                errors;
  logic              run_active;
  logic              pop_mode;

  cache_request_generator dut_i (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .descriptor_in      (descriptor_in),
    .request_in         (request_in),
    .arbiter_request_in (arbiter_request_in),
    .arbiter_grant_out  (arbiter_grant_out),
    .pop_en             (pop_en),
    .fifo_status_out    (fifo_status_out),
    .request_out        (request_out),
    .request_out_valid  (request_out_valid),
    .fifo_setup         (fifo_setup)
  );

  // --------------------------------------
  // Helpers
  // --------------------------------------
  // Next released row owned by req, at or after from
  function automatic int next_entry(int req, int from);
    for (int k = from; k < release_cnt; k++) begin
      if (int'(stim_table[k].req) == req) begin
        return k;
      end
    end
    return -1;
  endfunction

  function automatic logic is_memory_cmd(cmd_t cmd);
    return (cmd == cmd_mem_read) || (cmd == cmd_mem_write);
  endfunction

  // Reference decode
  function automatic cache_request_t expected_request(stim_t s);
    cache_request_t    r;
    logic [addr_w-1:0] base;
    base = base_tab[0];
    // Exactly one bit set picks that bit's buffer, others fall back to buffer 0
    if ($countones(s.id_buffer) == 1) begin
      for (int b = 0; b < num_buffers; b++) begin
        if (s.id_buffer[b]) begin
          base = base_tab[b+1];
        end
      end
    end
    r.source_id = s.req;
    r.cmd       = s.cmd;
    r.addr      = base + s.offset;
    r.wdata     = s.data;
    r.wstrb     = (s.cmd == cmd_mem_write) ? {strb_w{1'b1}} : '0;
    return r;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic finish_run();
    $display("Run complete: %0d error(s), %0d of %0d requests checked",
             errors, checked_cnt, exp_total);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // --------------------------------------
  // Clock and watchdog
  // --------------------------------------
  initial begin
    ap_clk = 1'b0;
    forever #4 ap_clk = ~ap_clk;
  end

  initial begin
    repeat (timeout_cycles) @(posedge ap_clk);
    report_failure($sformatf("timeout, run still busy after %0d cycles", timeout_cycles));
    finish_run();
  end

  // --------------------------------------
  // Drivers, reference model, output check
  // --------------------------------------
  // Random pop strobe, or held low for the burst
  initial begin
    void'($urandom(32'h11b4fb22));
    pop_en <= 1'b0;
    forever begin
      @(posedge ap_clk);
      pop_en <= pop_mode ? (($urandom % 4) != 0) : 1'b0;
    end
  end

  always @(posedge ap_clk) begin
    cache_request_t exp_req;
    cache_request_t got_req;
    if ($countones(arbiter_grant_out) > 1) begin
      report_failure("more than one grant in one cycle");
    end
    for (int i = 0; i < num_requestors; i++) begin
      if (arbiter_grant_out[i]) begin
        if (cur[i] < 0) begin
          report_failure($sformatf("grant to requestor %0d with nothing to send", i));
        end else begin
          for (int j = 0; j < num_requestors; j++) begin
            if (j != i && cur[j] >= 0 && last_grant == i) begin
              report_failure($sformatf("requestor %0d granted twice while %0d waits", i, j));
            end
          end
          // Queue order follows grant order
          if (is_memory_cmd(stim_table[cur[i]].cmd)) begin
            exp_q.push_back(expected_request(stim_table[cur[i]]));
          end
          grant_cnt++;
          last_grant = i;
          pos[i]     = cur[i] + 1;
        end
      end
      // Present the next row, or drop the request
      cur[i] = run_active ? next_entry(i, pos[i]) : -1;
      arbiter_request_in[i] <= (cur[i] >= 0);
      if (cur[i] >= 0) begin
        request_in[i] <= '{valid: 1'b1, source_id: stim_table[cur[i]].req,
                           cmd: stim_table[cur[i]].cmd,
                           id_buffer: stim_table[cur[i]].id_buffer,
                           offset: stim_table[cur[i]].offset,
                           data: stim_table[cur[i]].data};
      end else begin
        request_in[i] <= '0;
      end
    end
    if (request_out_valid) begin
      got_req = request_out;
      if (exp_q.size() == 0) begin
        report_failure("request_out valid with no request expected");
      end else begin
        exp_req = exp_q.pop_front();
        check_value("source_id", 64'(got_req.source_id), 64'(exp_req.source_id));
        check_value("cmd", 64'(got_req.cmd), 64'(exp_req.cmd));
        check_value("addr", 64'(got_req.addr), 64'(exp_req.addr));
        check_value("wdata", 64'(got_req.wdata), 64'(exp_req.wdata));
        check_value("wstrb", 64'(got_req.wstrb), 64'(exp_req.wstrb));
        checked_cnt++;
      end
    end
  end

  // --------------------------------------
  // Test sequence
  // --------------------------------------
  initial begin
    kernel_descriptor_t desc;
    errors      = 0;
    grant_cnt   = 0;
    checked_cnt = 0;
    exp_total   = 0;
    last_grant  = -1;
    release_cnt = 0;
    run_active  = 1'b0;
    pop_mode    = 1'b0;
    for (int i = 0; i < num_requestors; i++) begin
      cur[i] = -1;
      pos[i] = 0;
    end
    for (int k = 0; k < table_len; k++) begin
      if (is_memory_cmd(stim_table[k].cmd)) begin
        exp_total++;
      end
    end
    // Distinct bases, so a wrong select shows in addr
    for (int b = 0; b <= num_buffers; b++) begin
      base_tab[b] = 32'h0001_0000 * (b + 1) + 32'h0000_0100 * b;
    end
    desc = '{valid: 1'b1, buffer_0: base_tab[0], buffer_1: base_tab[1],
             buffer_2: base_tab[2], buffer_3: base_tab[3], buffer_4: base_tab[4],
             buffer_5: base_tab[5], buffer_6: base_tab[6], buffer_7: base_tab[7],
             buffer_8: base_tab[8]};
    areset_control     <= 1'b1;
    descriptor_in      <= '0;
    request_in         <= '0;
    arbiter_request_in <= '0;
    repeat (4) @(posedge ap_clk);
    areset_control <= 1'b0;
    descriptor_in  <= desc;
    #1;
    check_value("request_out_valid in reset", 64'(request_out_valid), '0);
    check_value("arbiter_grant_out in reset", 64'(arbiter_grant_out), '0);
    check_value("empty in reset", 64'(fifo_status_out.empty), 64'(1'b1));
    check_value("full in reset", 64'(fifo_status_out.full), '0);
    check_value("prog_full in reset", 64'(fifo_status_out.prog_full), '0);
    check_value("fifo_setup in reset", 64'(fifo_setup), 64'(1'b1));
    // Descriptor must survive its valid bit going low
    @(posedge ap_clk);
    descriptor_in <= '0;
    @(posedge ap_clk);
    #1;
    check_value("fifo_setup two cycles after reset", 64'(fifo_setup), '0);

    // Mixed traffic with random pops
    @(negedge ap_clk);
    run_active  = 1'b1;
    release_cnt = phase_a_len;
    pop_mode    = 1'b1;
    while (grant_cnt < release_cnt || exp_q.size() != 0) @(negedge ap_clk);
    for (int n = 0; n < 20 && !fifo_status_out.empty; n++) @(negedge ap_clk);
    check_value("empty after mixed traffic", 64'(fifo_status_out.empty), 64'(1'b1));

    // Burst with pops held off
    pop_mode    = 1'b0;
    release_cnt = table_len;
    while (grant_cnt < table_len) @(negedge ap_clk);
    check_value("prog_full before last push lands", 64'(fifo_status_out.prog_full), '0);
    for (int n = 0; n < 10 && !fifo_status_out.prog_full; n++) @(negedge ap_clk);
    check_value("prog_full after burst", 64'(fifo_status_out.prog_full), 64'(1'b1));
    check_value("empty during burst", 64'(fifo_status_out.empty), '0);
    check_value("full during burst", 64'(fifo_status_out.full), '0);

    // Drain
    pop_mode = 1'b1;
    while (exp_q.size() != 0) @(negedge ap_clk);
    for (int n = 0; n < 20 && !fifo_status_out.empty; n++) @(negedge ap_clk);
    check_value("empty after drain", 64'(fifo_status_out.empty), 64'(1'b1));
    // Late extra outputs would show as unexpected here
    repeat (10) @(negedge ap_clk);
    finish_run();
  end

endmodule

/* design/cache_request_generator.sv */
// Top level of the cache request generator, arbiter to decode to request FIFO
`timescale 1ns/100ps

module cache_request_generator (
  input  logic                                                  ap_clk,
  input  logic                                                  areset_control,
  input  cache_pkg::kernel_descriptor_t                         descriptor_in,
  input  cache_pkg::mem_packet_t [cache_pkg::num_requestors-1:0] request_in,
  input  logic [cache_pkg::num_requestors-1:0]                  arbiter_request_in,
  output logic [cache_pkg::num_requestors-1:0]                  arbiter_grant_out,
  input  logic                                                  pop_en,
  output cache_pkg::fifo_status_t                               fifo_status_out,
  output cache_pkg::cache_request_t                             request_out,
  output logic                                                  request_out_valid,
  output logic                                                  fifo_setup
);
  import cache_pkg::*;

  kernel_descriptor_t        descriptor_reg;
  logic                      pop_en_reg;
  logic [num_requestors-1:0] grant;
  mem_packet_t               arb_packet;
  cache_request_t            dec_request;
  logic                      dec_push;
  cache_request_t            fifo_dout;
  logic                      fifo_valid;
  logic                      fifo_pop;
  fifo_status_t              fifo_status;
  logic                      fifo_setup_int;

  // --------------------------------------
  // Descriptor and pop strobe
  // --------------------------------------
  // Held until the next valid descriptor
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      descriptor_reg.valid <= 1'b0;
      pop_en_reg           <= 1'b0;
    end else begin
      if (descriptor_in.valid) begin
        descriptor_reg <= descriptor_in;
      end
      pop_en_reg <= pop_en;
    end
  end

  // No pop on an empty FIFO
  assign fifo_pop = pop_en_reg & ~fifo_status.empty;

  // --------------------------------------
  // Select, decode, queue
  // --------------------------------------
  request_arbiter arbiter_i (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .request_in         (request_in),
    .arbiter_request_in (arbiter_request_in),
    .grant              (grant),
    .arb_packet         (arb_packet)
  );

  request_address_decode decode_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .descriptor     (descriptor_reg),
    .arb_packet     (arb_packet),
    .dec_request    (dec_request),
    .dec_push       (dec_push)
  );

  request_fifo fifo_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .push           (dec_push),
    .din            (dec_request),
    .pop            (fifo_pop),
    .dout           (fifo_dout),
    .dout_valid     (fifo_valid),
    .status         (fifo_status),
    .setup          (fifo_setup_int)
  );

  // --------------------------------------
  // Output registers
  // --------------------------------------
  always_ff @(posedge ap_clk) begin
    request_out <= fifo_dout;
    if (areset_control) begin
      arbiter_grant_out <= '0;
      request_out_valid <= 1'b0;
      fifo_setup        <= 1'b1;
      fifo_status_out   <= '{full: 1'b0, prog_full: 1'b0, empty: 1'b1};
    end else begin
      arbiter_grant_out <= grant;
      request_out_valid <= fifo_valid;
      fifo_setup        <= fifo_setup_int;
      fifo_status_out   <= fifo_status;
    end
  end

endmodule

/* design/request_fifo.sv */
// Inferred synchronous FIFO holding cache requests until the cache front end pops them
`timescale 1ns/100ps

module request_fifo (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic                      push,
  input  cache_pkg::cache_request_t din,
  input  logic                      pop,
  output cache_pkg::cache_request_t dout,
  output logic                      dout_valid,
  output cache_pkg::fifo_status_t   status,
  output logic                      setup
);
  import cache_pkg::*;

  cache_request_t     mem [fifo_depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [count_w-1:0] count;
  logic               push_ok;
  logic               pop_ok;

  // Status lags count by a cycle, so guard on count itself
  assign push_ok = push & (count != count_w'(fifo_depth));
  assign pop_ok  = pop & (count != '0);

  // --------------------------------------
  // Storage and read port
  // --------------------------------------
  always_ff @(posedge ap_clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= din;
    end
    if (pop_ok) begin
      dout <= mem[rd_ptr];
    end
  end

  // --------------------------------------
  // Pointers and occupancy
  // --------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Flags, read valid and setup level
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      status.full      <= 1'b0;
      status.prog_full <= 1'b0;
      status.empty     <= 1'b1;
      dout_valid       <= 1'b0;
      setup            <= 1'b1;
    end else begin
      status.full      <= (count == count_w'(fifo_depth));
      status.prog_full <= (count >= count_w'(prog_thresh));
      status.empty     <= (count == '0);
      dout_valid       <= pop_ok;
      // Pointers are clear by now
      setup            <= 1'b0;
    end
  end

endmodule

/* design/request_address_decode.sv */
// Address decode stage that turns a granted packet into a filtered, registered cache request
`timescale 1ns/100ps

module request_address_decode (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  cache_pkg::kernel_descriptor_t descriptor,
  input  cache_pkg::mem_packet_t        arb_packet,
  output cache_pkg::cache_request_t     dec_request,
  output logic                          dec_push
);
  import cache_pkg::*;

  logic [addr_w-1:0] address_base;
  cache_request_t    request_comb;
  logic              is_mem_cmd;
  logic              push_comb;

  // --------------------------------------
  // Base address select
  // --------------------------------------
  // Bit k of id_buffer picks buffer_(k+1)
  always_comb begin
    case (arb_packet.id_buffer)
      8'b0000_0001: address_base = descriptor.buffer_1;
      8'b0000_0010: address_base = descriptor.buffer_2;
      8'b0000_0100: address_base = descriptor.buffer_3;
      8'b0000_1000: address_base = descriptor.buffer_4;
      8'b0001_0000: address_base = descriptor.buffer_5;
      8'b0010_0000: address_base = descriptor.buffer_6;
      8'b0100_0000: address_base = descriptor.buffer_7;
      8'b1000_0000: address_base = descriptor.buffer_8;
      // Zero or several bits set
      default:      address_base = descriptor.buffer_0;
    endcase
  end

  // --------------------------------------
  // Request build
  // --------------------------------------
  always_comb begin
    request_comb.source_id = arb_packet.source_id;
    request_comb.cmd       = arb_packet.cmd;
    request_comb.addr      = address_base + arb_packet.offset;
    request_comb.wdata     = arb_packet.data;
    // Full-word strobe for writes only
    if (arb_packet.cmd == cmd_mem_write) begin
      request_comb.wstrb = {strb_w{1'b1}};
    end else begin
      request_comb.wstrb = '0;
    end
  end

  // Responses, engine and invalid commands are dropped here
  assign is_mem_cmd = (arb_packet.cmd == cmd_mem_read) | (arb_packet.cmd == cmd_mem_write);
  assign push_comb  = arb_packet.valid & descriptor.valid & is_mem_cmd;

  // Output register
  always_ff @(posedge ap_clk) begin
    dec_request <= request_comb;
    if (areset_control) begin
      dec_push <= 1'b0;
    end else begin
      dec_push <= push_comb;
    end
  end

endmodule

/* design/request_arbiter.sv */
// Round-robin arbiter that registers requestor packets and grants one per cycle
`timescale 1ns/100ps

module request_arbiter (
  input  logic                                                  ap_clk,
  input  logic                                                  areset_control,
  input  cache_pkg::mem_packet_t [cache_pkg::num_requestors-1:0] request_in,
  input  logic [cache_pkg::num_requestors-1:0]                  arbiter_request_in,
  output logic [cache_pkg::num_requestors-1:0]                  grant,
  output cache_pkg::mem_packet_t                                arb_packet
);
  import cache_pkg::*;

  mem_packet_t [num_requestors-1:0]                      request_reg;
  logic [num_requestors-1:0]                             request_level_reg;
  logic [num_requestors-1:0]                             eligible;
  logic [num_requestors-1:0]                             grant_next;
  logic [num_requestors-1:0]                             grant_mask;
  logic [grant_mask_depth-2:0][num_requestors-1:0]       grant_hist;
  logic [source_w-1:0]                                   last_idx;
  logic [source_w-1:0]                                   pick_idx;
  mem_packet_t                                           pick_packet;

  // --------------------------------------
  // Input registers
  // --------------------------------------
  always_ff @(posedge ap_clk) begin
    request_reg <= request_in;
    if (areset_control) begin
      request_level_reg <= '0;
      for (int i = 0; i < num_requestors; i++) begin
        request_reg[i].valid <= 1'b0;
      end
    end else begin
      request_level_reg <= arbiter_request_in;
    end
  end

  // Recent grants stay masked until the next packet lands in request_reg
  always_comb begin
    grant_mask = grant;
    for (int d = 0; d < grant_mask_depth - 1; d++) begin
      grant_mask = grant_mask | grant_hist[d];
    end
  end

  // --------------------------------------
  // Rotating priority pick
  // --------------------------------------
  always_comb begin
    int idx;
    for (int i = 0; i < num_requestors; i++) begin
      eligible[i] = request_level_reg[i] & request_reg[i].valid & ~grant_mask[i];
    end
    grant_next = '0;
    pick_idx   = last_idx;
    // Search starts one past the last winner
    for (int k = 1; k <= num_requestors; k++) begin
      idx = (int'(last_idx) + k) % num_requestors;
      if (!(|grant_next) && eligible[idx]) begin
        grant_next[idx] = 1'b1;
        pick_idx        = source_w'(idx);
      end
    end
    pick_packet       = request_reg[pick_idx];
    pick_packet.valid = |grant_next;
  end

  // Grant and packet out, plus grant history
  always_ff @(posedge ap_clk) begin
    arb_packet <= pick_packet;
    if (areset_control) begin
      grant            <= '0;
      grant_hist       <= '0;
      last_idx         <= source_w'(num_requestors - 1);
      arb_packet.valid <= 1'b0;
    end else begin
      grant         <= grant_next;
      grant_hist[0] <= grant;
      for (int d = 1; d < grant_mask_depth - 1; d++) begin
        grant_hist[d] <= grant_hist[d-1];
      end
      if (|grant_next) begin
        last_idx <= pick_idx;
      end
    end
  end

endmodule

/* design/cache_pkg.sv */
// Shared widths, command codes and bus structs, imported by every cache request generator block
package cache_pkg;

  // --------------------------------------
  // Sizes
  // --------------------------------------
  localparam int num_requestors = 2;
  localparam int source_w       = (num_requestors > 1) ? $clog2(num_requestors) : 1;
  localparam int addr_w         = 32;
  localparam int data_w         = 32;
  localparam int strb_w         = data_w / 8;
  localparam int num_buffers    = 8;

  // Request FIFO geometry
  localparam int fifo_depth     = 16;
  localparam int prog_thresh    = 12;
  localparam int ptr_w          = $clog2(fifo_depth);
  localparam int count_w        = $clog2(fifo_depth + 1);

  // Grant round trip through the requestor, in arbiter decisions
  // Covers grant reg, top-level grant reg and requestor input reg
  localparam int grant_mask_depth = 3;

  // --------------------------------------
  // Command codes
  // --------------------------------------
  typedef enum logic [2:0] {
    cmd_invalid      = 3'd0,
    cmd_mem_read     = 3'd1,
    cmd_mem_write    = 3'd2,
    cmd_mem_response = 3'd3,
    cmd_engine       = 3'd4
  } cmd_t;

  // --------------------------------------
  // Buses
  // --------------------------------------
  // Generic packet from an engine requestor
  typedef struct packed {
    logic                   valid;
    logic [source_w-1:0]    source_id;
    cmd_t                   cmd;
    logic [num_buffers-1:0] id_buffer;   // one-hot buffer select
    logic [addr_w-1:0]      offset;
    logic [data_w-1:0]      data;
  } mem_packet_t;

  // Base addresses, buffer_0 is the fallback
  typedef struct packed {
    logic              valid;
    logic [addr_w-1:0] buffer_0;
    logic [addr_w-1:0] buffer_1;
    logic [addr_w-1:0] buffer_2;
    logic [addr_w-1:0] buffer_3;
    logic [addr_w-1:0] buffer_4;
    logic [addr_w-1:0] buffer_5;
    logic [addr_w-1:0] buffer_6;
    logic [addr_w-1:0] buffer_7;
    logic [addr_w-1:0] buffer_8;
  } kernel_descriptor_t;

  // Request as seen by the cache front end
  typedef struct packed {
    logic [source_w-1:0] source_id;
    cmd_t                cmd;
    logic [addr_w-1:0]   addr;
    logic [data_w-1:0]   wdata;
    logic [strb_w-1:0]   wstrb;
  } cache_request_t;

  typedef struct packed {
    logic full;
    logic prog_full;
    logic empty;
  } fifo_status_t;

endpackage
